/* design/cpu_fetch.sv */
// -------------------------------------------------
// fetch front end top: counter, address, translation
// and memory stages in a chain, plus the test markers
// -------------------------------------------------

`timescale 1ns/1ps

module cpu_fetch (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            run,
  input  logic [fetch_pkg::VADDR_W-1:0]   start_vaddr,
  output logic                            ram_inst_stb,
  output logic [imem_pkg::RAM_ADDR_W-1:0] ram_inst_addr,
  input  logic [imem_pkg::LINE_W-1:0]     ram_inst_dout,
  input  logic                            ram_inst_ack,
  input  logic                            ram_inst_timeout,
  output logic                            rom_inst_stb,
  output logic [imem_pkg::ROM_ADDR_W-1:0] rom_inst_addr,
  input  logic [imem_pkg::LINE_W-1:0]     rom_inst_dout,
  input  logic                            rom_inst_ack,
  input  logic                            rom_inst_timeout,
  output logic                            inst_valid,
  output logic [imem_pkg::INST_W-1:0]     inst,
  output logic                            fault,
  output logic [31:0]                     crc,
  output logic                            test_step,   // delayed step pulse
  output logic                            test_good,   // step translated right
  output logic                            test_ended   // last address reached
);

  logic                          cnt_valid;
  logic [fetch_pkg::COUNT_W-1:0] cnt_count;
  logic                          va_ready;
  logic                          va_valid;
  logic [fetch_pkg::VADDR_W-1:0] va_vaddr;
  logic                          tr_ready;
  logic                          tr_valid;
  logic [fetch_pkg::PADDR_W-1:0] tr_paddr;
  logic                          mem_ready;

  // -------------------------------------------------
  // stage chain
  // -------------------------------------------------
  fetch_counter u_counter (
    .clk   (clk),
    .rst   (rst),
    .run   (run),
    .ready (va_ready),
    .valid (cnt_valid),
    .count (cnt_count)
  );

  fetch_vaddr u_vaddr (
    .clk         (clk),
    .rst         (rst),
    .start_vaddr (start_vaddr),
    .in_valid    (cnt_valid),
    .in_ready    (va_ready),
    .count       (cnt_count),
    .out_ready   (tr_ready),
    .out_valid   (va_valid),
    .vaddr       (va_vaddr)
  );

  fetch_translate u_translate (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (va_valid),
    .in_ready  (tr_ready),
    .vaddr     (va_vaddr),
    .out_ready (mem_ready),
    .out_valid (tr_valid),
    .paddr     (tr_paddr)
  );

  fetch_mem u_mem (
    .clk              (clk),
    .rst              (rst),
    .in_valid         (tr_valid),
    .in_ready         (mem_ready),
    .paddr            (tr_paddr),
    .ram_inst_stb     (ram_inst_stb),
    .ram_inst_addr    (ram_inst_addr),
    .ram_inst_dout    (ram_inst_dout),
    .ram_inst_ack     (ram_inst_ack),
    .ram_inst_timeout (ram_inst_timeout),
    .rom_inst_stb     (rom_inst_stb),
    .rom_inst_addr    (rom_inst_addr),
    .rom_inst_dout    (rom_inst_dout),
    .rom_inst_ack     (rom_inst_ack),
    .rom_inst_timeout (rom_inst_timeout),
    .inst_valid       (inst_valid),
    .inst             (inst),
    .fault            (fault),
    .crc              (crc)
  );

  // -------------------------------------------------
  // test markers
  // -------------------------------------------------
  logic step_hit;

  assign step_hit = va_valid && (va_vaddr == fetch_pkg::STEP_VADDR);

  always_ff @(posedge clk) begin
    if (rst) begin
      test_step <= 1'b0;
    end else begin
      test_step <= step_hit;  // one cycle behind the address stage
    end
  end

  assign test_good  = tr_valid && (tr_paddr == fetch_pkg::GOOD_PADDR);
  assign test_ended = va_valid && (va_vaddr == fetch_pkg::END_VADDR);

endmodule

/* design/fetch_counter.sv */
// -------------------------------------------------
// source of fetch sequence numbers, valid while run
// is high, count restarts at 0 whenever run drops
// -------------------------------------------------

`timescale 1ns/1ps

module fetch_counter (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         run,
  input  logic                         ready,
  output logic                         valid,
  output logic [fetch_pkg::COUNT_W-1:0] count
);

  logic [fetch_pkg::COUNT_W-1:0] count_q;
  logic                          xfer;

  // a new number is on offer in every running cycle
  assign valid = run && !rst;
  assign xfer  = valid && ready;
  assign count = count_q;

  // -------------------------------------------------
  // sequence register
  // -------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else if (!run) begin
      count_q <= '0;              // restart point for the next run
    end else if (xfer) begin
      count_q <= count_q + 1'b1;  // wraps after 1023
    end
  end

endmodule

/* design/fetch_mem.sv */
// -------------------------------------------------
// fetch unit: one line buffer, ram/rom line requests over
// stb/ack/timeout, word select and running crc-32
// -------------------------------------------------

`timescale 1ns/1ps

module fetch_mem (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             in_valid,
  output logic                             in_ready,
  input  logic [fetch_pkg::PADDR_W-1:0]    paddr,
  // ram line bus
  output logic                             ram_inst_stb,
  output logic [imem_pkg::RAM_ADDR_W-1:0]  ram_inst_addr,
  input  logic [imem_pkg::LINE_W-1:0]      ram_inst_dout,
  input  logic                             ram_inst_ack,
  input  logic                             ram_inst_timeout,
  // rom line bus
  output logic                             rom_inst_stb,
  output logic [imem_pkg::ROM_ADDR_W-1:0]  rom_inst_addr,
  input  logic [imem_pkg::LINE_W-1:0]      rom_inst_dout,
  input  logic                             rom_inst_ack,
  input  logic                             rom_inst_timeout,
  // delivery
  output logic                             inst_valid,
  output logic [imem_pkg::INST_W-1:0]      inst,
  output logic                             fault,
  output logic [31:0]                      crc
);

  imem_pkg::mem_state_t state;

  logic [fetch_pkg::PADDR_W-1:0]   paddr_q;     // address being served
  logic [imem_pkg::LINE_W-1:0]     line_buf;
  logic                            buf_valid;
  logic                            buf_rom;     // buffered line came from rom
  logic [imem_pkg::RAM_ADDR_W-1:0] buf_line;    // rom lines zero extended
  logic                            in_rom;
  logic [imem_pkg::RAM_ADDR_W-1:0] in_line;
  logic                            hit;

  // -------------------------------------------------
  // crc-32 over one word, msb first
  // -------------------------------------------------
  function automatic logic [31:0] crc_word(input logic [31:0] crc_in,
                                           input logic [31:0] data);
    logic [31:0] c;
    logic        fb;
    c = crc_in;
    for (int i = 31; i >= 0; i--) begin
      fb = c[31] ^ data[i];
      c  = {c[30:0], 1'b0};
      if (fb) begin
        c = c ^ imem_pkg::CRC_POLY;
      end
    end
    return c;
  endfunction

  // -------------------------------------------------
  // hit check on the incoming address
  // -------------------------------------------------
  assign in_rom  = paddr[29];
  assign in_line = in_rom ? {1'b0, paddr[27:4]} : paddr[28:4];
  assign hit     = buf_valid && (buf_rom == in_rom) && (buf_line == in_line);

  assign in_ready = (state == imem_pkg::IDLE);

  // bus side, address held from the latched paddr
  assign ram_inst_stb  = (state == imem_pkg::REQ_RAM);
  assign rom_inst_stb  = (state == imem_pkg::REQ_ROM);
  assign ram_inst_addr = paddr_q[28:4];
  assign rom_inst_addr = paddr_q[27:4];

  // word 0 sits in bits 31:0
  assign inst       = line_buf[paddr_q[3:2]*imem_pkg::INST_W +: imem_pkg::INST_W];
  assign inst_valid = (state == imem_pkg::DELIVER);

  // -------------------------------------------------
  // sequencer
  // -------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= imem_pkg::IDLE;
      buf_valid <= 1'b0;
      fault     <= 1'b0;
      crc       <= imem_pkg::CRC_INIT;
    end else begin
      fault <= 1'b0;
      case (state)
        imem_pkg::IDLE: begin
          if (in_valid) begin
            if (hit) begin
              state <= imem_pkg::DELIVER;
            end else if (in_rom) begin
              state <= imem_pkg::REQ_ROM;
            end else begin
              state <= imem_pkg::REQ_RAM;
            end
          end
        end
        imem_pkg::REQ_RAM: begin
          if (ram_inst_ack) begin
            buf_valid <= 1'b1;
            state     <= imem_pkg::DELIVER;
          end else if (ram_inst_timeout) begin
            buf_valid <= 1'b0;              // line lost, refetch next time
            fault     <= 1'b1;
            state     <= imem_pkg::IDLE;
          end
        end
        imem_pkg::REQ_ROM: begin
          if (rom_inst_ack) begin
            buf_valid <= 1'b1;
            state     <= imem_pkg::DELIVER;
          end else if (rom_inst_timeout) begin
            buf_valid <= 1'b0;
            fault     <= 1'b1;
            state     <= imem_pkg::IDLE;
          end
        end
        imem_pkg::DELIVER: begin
          crc   <= crc_word(crc, inst);
          state <= imem_pkg::IDLE;
        end
        default: state <= imem_pkg::IDLE;
      endcase
    end
  end

  // -------------------------------------------------
  // payload: latched address, buffer line and tag
  // -------------------------------------------------
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      paddr_q <= paddr;
    end
    if (ram_inst_stb && ram_inst_ack) begin
      line_buf <= ram_inst_dout;
      buf_rom  <= 1'b0;
      buf_line <= paddr_q[28:4];
    end
    if (rom_inst_stb && rom_inst_ack) begin
      line_buf <= rom_inst_dout;
      buf_rom  <= 1'b1;
      buf_line <= {1'b0, paddr_q[27:4]};
    end
  end

endmodule

/* design/fetch_pkg.sv */
// -------------------------------------------------
// pipeline constants for the fetch front end
// address widths, address map and test marker addresses
// -------------------------------------------------

package fetch_pkg;

  // -------------------------------------------------
  // widths
  // -------------------------------------------------
  localparam int COUNT_W = 10;   // fetch sequence number
  localparam int VADDR_W = 32;   // virtual address
  localparam int PADDR_W = 30;   // physical address

  // -------------------------------------------------
  // address map
  // -------------------------------------------------

  // vaddr[31:30] of the directly mapped kernel segment
  localparam logic [1:0] KSEG_TAG = 2'b11;

  // user space sits this far above its physical location
  localparam logic [VADDR_W-1:0] USER_OFFSET = 32'h0000_1000;

  // -------------------------------------------------
  // test markers
  // -------------------------------------------------

  // vaddr that triggers the delayed step pulse
  localparam logic [VADDR_W-1:0] STEP_VADDR = 32'h0000_6034;

  // paddr of STEP_VADDR after user translation
  localparam logic [PADDR_W-1:0] GOOD_PADDR = 30'h0000_5034;

  // last address of the test program
  localparam logic [VADDR_W-1:0] END_VADDR = 32'h0000_603C;

endpackage

/* design/fetch_translate.sv */
// -------------------------------------------------
// translation stage, maps a virtual address to a 30 bit
// physical address, kernel segment direct, user offset
// -------------------------------------------------

`timescale 1ns/1ps

module fetch_translate (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_valid,
  output logic                          in_ready,
  input  logic [fetch_pkg::VADDR_W-1:0] vaddr,
  input  logic                          out_ready,
  output logic                          out_valid,
  output logic [fetch_pkg::PADDR_W-1:0] paddr
);

  logic                          kseg;
  logic [fetch_pkg::VADDR_W-1:0] user_vaddr;
  logic [fetch_pkg::PADDR_W-1:0] mapped;
  logic                          load;

  // -------------------------------------------------
  // mapping rule
  // -------------------------------------------------
  assign kseg       = (vaddr[31:30] == fetch_pkg::KSEG_TAG);
  assign user_vaddr = vaddr - fetch_pkg::USER_OFFSET;

  always_comb begin
    if (kseg) begin
      mapped = vaddr[fetch_pkg::PADDR_W-1:0];       // top two bits dropped
    end else begin
      mapped = user_vaddr[fetch_pkg::PADDR_W-1:0];
    end
  end

  // -------------------------------------------------
  // stage register
  // -------------------------------------------------
  assign in_ready = !out_valid || out_ready;
  assign load     = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      paddr <= mapped;
    end
  end

endmodule

/* design/fetch_vaddr.sv */
// -------------------------------------------------
// address stage, turns a sequence number into a word
// aligned virtual address, one entry deep
// -------------------------------------------------

`timescale 1ns/1ps

module fetch_vaddr (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [fetch_pkg::VADDR_W-1:0] start_vaddr,
  input  logic                          in_valid,
  output logic                          in_ready,
  input  logic [fetch_pkg::COUNT_W-1:0] count,
  input  logic                          out_ready,
  output logic                          out_valid,
  output logic [fetch_pkg::VADDR_W-1:0] vaddr
);

  localparam int PAD_W = fetch_pkg::VADDR_W - fetch_pkg::COUNT_W - 2;

  logic [fetch_pkg::VADDR_W-1:0] byte_offset;
  logic                          load;

  // count * 4, widened to a full address
  assign byte_offset = {{PAD_W{1'b0}}, count, 2'b00};

  // take a new item if empty or if the held one leaves now
  assign in_ready = !out_valid || out_ready;
  assign load     = in_valid && in_ready;

  // -------------------------------------------------
  // stage register
  // -------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;  // item taken, nothing new behind it
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      vaddr <= start_vaddr + byte_offset;
    end
  end

endmodule

/* design/imem_pkg.sv */
// -------------------------------------------------
// instruction memory bus widths, CRC constants and
// the state type of the fetch unit
// -------------------------------------------------

package imem_pkg;

  // -------------------------------------------------
  // bus widths
  // -------------------------------------------------
  localparam int LINE_W     = 128;  // one memory line, four words
  localparam int RAM_ADDR_W = 25;   // ram line address
  localparam int ROM_ADDR_W = 24;   // rom line address
  localparam int INST_W     = 32;   // one instruction word

  // -------------------------------------------------
  // crc-32, msb first, no reflection, no final xor
  // -------------------------------------------------
  localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;
  localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

  // -------------------------------------------------
  // fetch unit states
  // -------------------------------------------------
  typedef enum logic [1:0] {
    IDLE,     // waiting for a paddr
    REQ_RAM,  // ram line request in flight
    REQ_ROM,  // rom line request in flight
    DELIVER   // word out, crc update
  } mem_state_t;

endpackage

/* list.f */
design/fetch_pkg.sv
design/imem_pkg.sv
design/fetch_counter.sv
design/fetch_vaddr.sv
design/fetch_translate.sv
design/fetch_mem.sv
design/cpu_fetch.sv
verif/cpu_fetch_sva.sv
verif/tb_cpu_fetch.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the fetch front end testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module tb_cpu_fetch
./obj_dir/Vtb_cpu_fetch | tee sim.log

if grep -q "Finished with no errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* verif/cpu_fetch_sva.sv */
// -------------------------------------------------
// bus and handshake assertions, bound into cpu_fetch
// -------------------------------------------------

`timescale 1ns/1ps

module cpu_fetch_sva (
  input logic                            clk,
  input logic                            rst,
  input logic                            ram_inst_stb,
  input logic [imem_pkg::RAM_ADDR_W-1:0] ram_inst_addr,
  input logic                            ram_inst_ack,
  input logic                            ram_inst_timeout,
  input logic                            rom_inst_stb,
  input logic [imem_pkg::ROM_ADDR_W-1:0] rom_inst_addr,
  input logic                            rom_inst_ack,
  input logic                            rom_inst_timeout,
  input logic                            va_valid,
  input logic [fetch_pkg::VADDR_W-1:0]   va_vaddr,
  input logic                            tr_ready,
  input logic                            tr_valid,
  input logic [fetch_pkg::PADDR_W-1:0]   tr_paddr,
  input logic                            mem_ready
);

  a_one_stb: assert property (@(posedge clk) disable iff (rst)
    !(ram_inst_stb && rom_inst_stb)) else $error("ram and rom strobes high together");

  // request held until ack or timeout
  a_ram_hold: assert property (@(posedge clk) disable iff (rst)
    ram_inst_stb && !ram_inst_ack && !ram_inst_timeout |=>
    ram_inst_stb && $stable(ram_inst_addr)) else $error("ram request dropped or moved");

  a_rom_hold: assert property (@(posedge clk) disable iff (rst)
    rom_inst_stb && !rom_inst_ack && !rom_inst_timeout |=>
    rom_inst_stb && $stable(rom_inst_addr)) else $error("rom request dropped or moved");

  // stalled stages keep their item
  a_va_hold: assert property (@(posedge clk) disable iff (rst)
    va_valid && !tr_ready |=> va_valid && $stable(va_vaddr))
    else $error("address stage changed while stalled");

  a_tr_hold: assert property (@(posedge clk) disable iff (rst)
    tr_valid && !mem_ready |=> tr_valid && $stable(tr_paddr))
    else $error("translation stage changed while stalled");

endmodule

bind cpu_fetch cpu_fetch_sva u_sva (.*);

/* verif/tb_cpu_fetch.sv */
// -------------------------------------------------
// testbench for the fetch front end with ram/rom line
// models, directed tests and a closing report line
// -------------------------------------------------

`timescale 1ns/1ps

module tb_cpu_fetch;

  localparam int WAIT_LIMIT = 500;  // cycles per wait loop
  localparam int EV_RAM     = 0;    // rising edge slots in ev
  localparam int EV_ROM     = 1;
  localparam int EV_FAULT   = 2;
  localparam int EV_STEP    = 3;
  localparam int EV_GOOD    = 4;
  localparam int EV_END     = 5;

  logic         clk = 1'b0;
  logic         rst = 1'b1;
  logic         run = 1'b0;
  logic [31:0]  start_vaddr = '0;
  logic         ram_inst_stb;
  logic [24:0]  ram_inst_addr;
  logic [127:0] ram_inst_dout = '0;
  logic         ram_inst_ack = 1'b0;
  logic         ram_inst_timeout = 1'b0;
  logic         rom_inst_stb;
  logic [23:0]  rom_inst_addr;
  logic [127:0] rom_inst_dout = '0;
  logic         rom_inst_ack = 1'b0;
  logic         rom_inst_timeout = 1'b0;
  logic         inst_valid;
  logic [31:0]  inst;
  logic         fault;
  logic [31:0]  crc;
  logic         test_step;
  logic         test_good;
  logic         test_ended;

  logic         fail_en = 1'b0;   // fail_line answers with timeout
  logic [24:0]  fail_line = '0;
  int           ram_wait = 0;
  int           rom_wait = 0;
  logic [31:0]  got_inst[$];      // every delivered word since reset
  logic [5:0]   ev;
  logic [5:0]   ev_q = '0;
  int           rise_cnt[6] = '{default: 0};
  int           rise_at[6] = '{default: 0};
  int           snap[6];
  int           cycle = 0;
  logic [31:0]  exp_crc = imem_pkg::CRC_INIT;
  int           errors = 0;
  int           tests_run = 0;
  int           failed_tests = 0;

  cpu_fetch u_dut (.*);

  always #50 clk = ~clk;

  // -------------------------------------------------
  // ram and rom line models
  // -------------------------------------------------
  function automatic logic [127:0] line_data(input logic rom, input logic [23:0] low);
    logic [127:0] d;
    for (int i = 0; i < 4; i++) begin
      d[i*32 +: 32] = {(rom ? 8'hC0 : 8'hA0) + 8'(i), low};
    end
    return d;
  endfunction

  always @(posedge clk) begin
    if (rst || ram_inst_ack || ram_inst_timeout) begin
      ram_inst_ack     <= 1'b0;
      ram_inst_timeout <= 1'b0;
      ram_wait = 0;
    end else if (ram_inst_stb) begin
      if (ram_wait == 0) begin
        ram_wait = 1 + int'($urandom % 4);  // new request
      end
      ram_wait = ram_wait - 1;
      if (ram_wait == 0 && fail_en && ram_inst_addr == fail_line) begin
        ram_inst_timeout <= 1'b1;
      end else if (ram_wait == 0) begin
        ram_inst_ack  <= 1'b1;
        ram_inst_dout <= line_data(1'b0, ram_inst_addr[23:0]);
      end
    end
  end

  always @(posedge clk) begin
    if (rst || rom_inst_ack) begin
      rom_inst_ack <= 1'b0;
      rom_wait = 0;
    end else if (rom_inst_stb) begin
      if (rom_wait == 0) begin
        rom_wait = 1 + int'($urandom % 4);
      end
      rom_wait = rom_wait - 1;
      if (rom_wait == 0) begin
        rom_inst_ack  <= 1'b1;
        rom_inst_dout <= line_data(1'b1, rom_inst_addr);
      end
    end
  end

  // -------------------------------------------------
  // monitor sampled mid cycle
  // -------------------------------------------------
  assign ev = {test_ended, test_good, test_step, fault, rom_inst_stb, ram_inst_stb};

  always @(negedge clk) begin
    if (!rst) begin
      if (inst_valid) begin
        got_inst.push_back(inst);
      end
      for (int i = 0; i < 6; i++) begin
        if (ev[i] && !ev_q[i]) begin
          rise_cnt[i] = rise_cnt[i] + 1;
          rise_at[i]  = cycle;
        end
      end
    end
    ev_q = ev;
    cycle++;
  end

  // -------------------------------------------------
  // expected values and checks
  // -------------------------------------------------

  // word i of a line carries the tag plus i and the line's low bits
  function automatic logic [31:0] expect_word(input logic [29:0] p);
    logic [7:0] tag;
    tag = (p[29] ? 8'hC0 : 8'hA0) + {6'd0, p[3:2]};
    return {tag, p[27:4]};
  endfunction

  // crc-32 a byte at a time with msb first and no reflection
  function automatic logic [31:0] crc_add(input logic [31:0] c_in, input logic [31:0] w);
    logic [31:0] r;
    r = c_in;
    for (int b = 3; b >= 0; b--) begin
      r = r ^ {w[b*8 +: 8], 24'h0};
      for (int k = 0; k < 8; k++) begin
        r = r[31] ? ({r[30:0], 1'b0} ^ imem_pkg::CRC_POLY) : {r[30:0], 1'b0};
      end
    end
    return r;
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("** Error at %0d ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
    errors++;
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      report_value(name, got, exp);
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("%s: passed", name);
    end else begin
      failed_tests++;
      $display("%s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  // n fetches from start and an in-order compare of the inst stream
  task automatic run_program(input logic [31:0] start, input int n);
    logic [31:0] exp_q[$];
    logic [31:0] v;
    logic [31:0] u;
    logic [29:0] p;
    int          base;
    int          sent;
    int          guard;
    base = got_inst.size();
    for (int k = 0; k < n; k++) begin
      v = start + 32'(4 * k);
      u = v - 32'h1000;                          // user segment offset
      p = (v[31:30] == 2'b11) ? v[29:0] : u[29:0];
      if (!(fail_en && !p[29] && p[28:4] == fail_line)) begin
        exp_q.push_back(expect_word(p));
      end
    end
    @(posedge clk);
    start_vaddr <= start;
    run         <= 1'b1;
    sent  = 0;
    guard = 0;
    while (sent < n && guard < WAIT_LIMIT) begin
      @(negedge clk);
      guard++;
      if (u_dut.cnt_valid && u_dut.va_ready) begin
        sent++;                                  // taken at the next edge
      end
    end
    @(posedge clk);
    run <= 1'b0;
    if (sent < n) begin
      $display("Error at %0d ns: only %0d of %0d fetches were issued", $time, sent, n);
      errors++;
    end
    guard = 0;
    do begin
      @(negedge clk);
      guard++;
    end while ((u_dut.va_valid || u_dut.tr_valid || !u_dut.mem_ready) && guard < WAIT_LIMIT);
    if (u_dut.va_valid || u_dut.tr_valid || !u_dut.mem_ready) begin
      $display("Error at %0d ns: pipeline did not drain in time", $time);
      errors++;
    end
    check_count("delivered words", got_inst.size() - base, exp_q.size());
    foreach (exp_q[k]) begin
      if (base + k < got_inst.size() && got_inst[base + k] !== exp_q[k]) begin
        report_value("inst", got_inst[base + k], exp_q[k]);
      end
      exp_crc = crc_add(exp_crc, exp_q[k]);
    end
  endtask

  // -------------------------------------------------
  // directed tests
  // -------------------------------------------------
  task automatic user_sequence();
    int e0;
    e0 = errors;
    run_program(32'h0000_6000, 16);
    finish_test("user_sequence", e0);
  endtask

  task automatic line_buffer();
    int e0;
    e0   = errors;
    snap = rise_cnt;
    run_program(32'h0000_6000, 16);
    check_count("ram_inst_stb pulses", rise_cnt[EV_RAM] - snap[EV_RAM], 4);
    check_count("rom_inst_stb pulses", rise_cnt[EV_ROM] - snap[EV_ROM], 0);
    finish_test("line_buffer", e0);
  endtask

  task automatic kernel_rom();
    int e0;
    e0   = errors;
    snap = rise_cnt;
    run_program(32'hE000_0000, 8);             // rom lines 0 and 1
    check_count("rom_inst_stb pulses", rise_cnt[EV_ROM] - snap[EV_ROM], 2);
    check_count("ram_inst_stb pulses", rise_cnt[EV_RAM] - snap[EV_RAM], 0);
    finish_test("kernel_rom", e0);
  endtask

  task automatic test_markers();
    int e0;
    e0   = errors;
    snap = rise_cnt;
    run_program(32'h0000_6000, 16);
    check_count("test_step pulses", rise_cnt[EV_STEP] - snap[EV_STEP], 1);
    check_count("test_good pulses", rise_cnt[EV_GOOD] - snap[EV_GOOD], 1);
    check_count("test_ended pulses", rise_cnt[EV_END] - snap[EV_END], 1);
    if (rise_at[EV_GOOD] >= rise_at[EV_END]) begin
      $display("Error at %0d ns: test_good did not come before test_ended", $time);
      errors++;
    end
    finish_test("test_markers", e0);
  endtask

  task automatic timeout_fault();
    int e0;
    e0        = errors;
    snap      = rise_cnt;
    fail_en   = 1'b1;
    fail_line = 25'h601;                       // second of three ram lines
    run_program(32'h0000_7000, 12);
    fail_en   = 1'b0;
    check_count("fault pulses", rise_cnt[EV_FAULT] - snap[EV_FAULT], 4);
    check_count("ram_inst_stb pulses", rise_cnt[EV_RAM] - snap[EV_RAM], 6);
    finish_test("timeout_fault", e0);
  endtask

  task automatic crc_check(input string after);
    int e0;
    e0 = errors;
    if (crc !== exp_crc) begin
      report_value("crc", crc, exp_crc);
    end
    finish_test({"crc_check after ", after}, e0);
  endtask

  initial begin
    void'($urandom(2593));
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    crc_check("reset");
    user_sequence();
    crc_check("user_sequence");
    line_buffer();
    crc_check("line_buffer");
    kernel_rom();
    crc_check("kernel_rom");
    test_markers();
    crc_check("test_markers");
    timeout_fault();
    crc_check("timeout_fault");
    $display("%0d tests, %0d failed, %0d errors", tests_run, failed_tests, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
